/* source/sd_host_consts.svh */
`ifndef SD_HOST_CONSTS_SVH
`define SD_HOST_CONSTS_SVH

// ------------------------------------------------------------------------
// bus widths of the host controller register port
// ------------------------------------------------------------------------
`define SD_ADDR_W 12 // register offset
`define SD_DATA_W 32 // register word

// ------------------------------------------------------------------------
// register map offsets
// ------------------------------------------------------------------------
`define SD_REG_BLK_COUNT     12'h006
`define SD_REG_ARGUMENT      12'h008
`define SD_REG_TF_MODE       12'h00C
`define SD_REG_COMMAND       12'h00E // writing this one sends the command
`define SD_REG_RESPONSE      12'h010
`define SD_REG_NORM_INT_STAT 12'h030 // write one to clear

// status bits in normal interrupt status
`define SD_BIT_CMD_COMPLETE 0
`define SD_BIT_TF_COMPLETE  1

// card status bit inside the R1 response
`define SD_BIT_READY_FOR_DATA 8

// poll phase limit in clk cycles, kept short for simulation
`define SD_POLL_TIMEOUT 200

`endif

/* source/sd_host_pkg.sv */
package sd_host_pkg;

	// sequencer steps, one per register access plus the bookends
	typedef enum logic [3:0] {
		idle,
		wr_blk_count,
		wr_argument,
		wr_tf_mode,
		wr_command,
		poll_cmd, // wait for command complete
		clr_cmd,
		rd_resp, // card status check
		start_dma,
		poll_tf, // wait for transfer complete
		clr_tf,
		finish
	} seq_state_e;

	// register access direction
	typedef enum logic {op_read, op_write} reg_op_e;

	// result code handed out with done
	typedef enum logic [2:0] {
		st_ok,
		st_not_ready,
		st_cmd_timeout,
		st_tf_timeout,
		st_bus_error
	} xfer_status_e;

endpackage

/* source/apb_reg_master.sv */
`timescale 1ns/1ns
`include "sd_host_consts.svh"

module apb_reg_master (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  req,
	input  sd_host_pkg::reg_op_e  op,
	input  logic [`SD_ADDR_W-1:0] addr,
	input  logic [`SD_DATA_W-1:0] wdata,
	output logic                  ready,
	output logic                  rsp_done,
	output logic [`SD_DATA_W-1:0] rdata,
	output logic                  rsp_err,
	output logic [`SD_ADDR_W-1:0] paddr,
	output logic                  psel,
	output logic                  penable,
	output logic                  pwrite,
	output logic [`SD_DATA_W-1:0] pwdata,
	input  logic [`SD_DATA_W-1:0] prdata,
	input  logic                  pready,
	input  logic                  pslverr
);

	typedef enum logic [1:0] {ap_idle, ap_setup, ap_access} apb_state_e;

	apb_state_e state;

	assign ready   = (state == ap_idle); // one request at a time
	assign psel    = (state != ap_idle);
	assign penable = (state == ap_access);

	// ------------------------------------------------------------------------
	// phase control
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= ap_idle;
			pwrite   <= 1'b0;
			rsp_done <= 1'b0;
		end else begin
			rsp_done <= 1'b0; // default, single cycle pulse
			case (state)
				ap_idle: if (req) begin
					state  <= ap_setup;
					pwrite <= (op == sd_host_pkg::op_write);
				end
				ap_setup: state <= ap_access; // always exactly one cycle
				ap_access: if (pready) begin // wait states stretch this phase
					state    <= ap_idle;
					rsp_done <= 1'b1;
				end
				default: state <= ap_idle;
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge clk) begin
		if (ready && req) begin
			paddr  <= addr;
			pwdata <= wdata;
		end
		if (penable && pready) begin
			rdata   <= prdata; // only meaningful for reads
			rsp_err <= pslverr;
		end
	end

	// access phase only ever entered from a selected setup phase
	a_enable_in_select: assert property (@(posedge clk) disable iff (reset)
		penable |-> (psel && $past(psel)));

	// address and write data frozen for the whole transfer
	a_stable_payload: assert property (@(posedge clk) disable iff (reset)
		(psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwdata)));

endmodule

/* source/poll_timer.sv */
`timescale 1ns/1ns
`include "sd_host_consts.svh"

module poll_timer #(
	parameter int LIMIT = `SD_POLL_TIMEOUT
) (
	input  logic clk,
	input  logic reset,
	input  logic restart,
	output logic expired
);

	localparam int CW = $clog2(LIMIT + 1);

	logic [CW-1:0] cnt;

	always_ff @(posedge clk) begin
		if (reset || restart) begin
			cnt     <= '0;
			expired <= 1'b0;
		end else if (!expired) begin // saturate once tripped
			cnt <= cnt + 1'b1;
			if (cnt == CW'(LIMIT - 1))
				expired <= 1'b1; // visible LIMIT cycles after restart
		end
	end

	// full quiet window after every restart
	a_no_early_expiry: assert property (@(posedge clk) disable iff (reset)
		restart |=> !expired [*LIMIT]);

endmodule

/* source/xfer_sequencer.sv */
`timescale 1ns/1ns
`include "sd_host_consts.svh"

module xfer_sequencer (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  logic [15:0]               blk_count,
	input  logic [31:0]               argument,
	input  logic [15:0]               tf_mode,
	input  logic [15:0]               command,
	output logic                      busy,
	output logic                      done,
	output logic                      start_adma,
	output sd_host_pkg::xfer_status_e xfer_status,
	output logic                      req,
	output sd_host_pkg::reg_op_e      op,
	output logic [`SD_ADDR_W-1:0]     addr,
	output logic [`SD_DATA_W-1:0]     wdata,
	input  logic                      ready,
	input  logic                      rsp_done,
	input  logic [`SD_DATA_W-1:0]     rdata,
	input  logic                      rsp_err,
	output logic                      restart,
	input  logic                      expired
);

	sd_host_pkg::seq_state_e   state;
	sd_host_pkg::xfer_status_e fin_code; // result waiting for the finish step
	logic                      pending;  // request out, no response yet
	logic                      issue;    // current step owns a register access
	logic                      accept;
	logic [15:0]               blk_count_r;
	logic [31:0]               argument_r;
	logic [15:0]               tf_mode_r;
	logic [15:0]               command_r;

	assign accept = start && (state == sd_host_pkg::idle); // busy is low only in idle

	// one request per access, held off while its response is outstanding
	assign req = issue && !pending;

	always_ff @(posedge clk) begin
		if (accept) begin
			blk_count_r <= blk_count;
			argument_r  <= argument;
			tf_mode_r   <= tf_mode;
			command_r   <= command;
		end
	end

	// ------------------------------------------------------------------------
	// register access per step, held steady until rsp_done
	// ------------------------------------------------------------------------
	always_comb begin
		issue = 1'b1;
		op    = sd_host_pkg::op_write;
		addr  = '0;
		wdata = '0;
		case (state)
			sd_host_pkg::wr_blk_count: begin
				addr  = `SD_REG_BLK_COUNT;
				wdata = `SD_DATA_W'(blk_count_r); // zero extended
			end
			sd_host_pkg::wr_argument: begin
				addr  = `SD_REG_ARGUMENT;
				wdata = `SD_DATA_W'(argument_r);
			end
			sd_host_pkg::wr_tf_mode: begin
				addr  = `SD_REG_TF_MODE;
				wdata = `SD_DATA_W'(tf_mode_r);
			end
			sd_host_pkg::wr_command: begin
				addr  = `SD_REG_COMMAND;
				wdata = `SD_DATA_W'(command_r);
			end
			sd_host_pkg::poll_cmd, sd_host_pkg::poll_tf: begin
				op   = sd_host_pkg::op_read;
				addr = `SD_REG_NORM_INT_STAT;
			end
			sd_host_pkg::clr_cmd: begin
				addr = `SD_REG_NORM_INT_STAT;
				wdata[`SD_BIT_CMD_COMPLETE] = 1'b1; // w1c, other flags untouched
			end
			sd_host_pkg::rd_resp: begin
				op   = sd_host_pkg::op_read;
				addr = `SD_REG_RESPONSE;
			end
			sd_host_pkg::clr_tf: begin
				addr = `SD_REG_NORM_INT_STAT;
				wdata[`SD_BIT_TF_COMPLETE] = 1'b1;
			end
			default: issue = 1'b0; // idle, start_dma, finish
		endcase
	end

	// ------------------------------------------------------------------------
	// step sequencing
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= sd_host_pkg::idle;
			pending     <= 1'b0;
			busy        <= 1'b0;
			done        <= 1'b0;
			start_adma  <= 1'b0;
			restart     <= 1'b0;
			fin_code    <= sd_host_pkg::st_ok;
			xfer_status <= sd_host_pkg::st_ok;
		end else begin
			done       <= 1'b0;
			start_adma <= 1'b0;
			restart    <= 1'b0;
			if (req)
				pending <= 1'b1;
			if (rsp_done)
				pending <= 1'b0;

			if (rsp_done && rsp_err) begin // any slave error aborts
				fin_code <= sd_host_pkg::st_bus_error;
				state    <= sd_host_pkg::finish;
			end else begin
				case (state)
					sd_host_pkg::idle: if (accept) begin
						busy  <= 1'b1;
						state <= sd_host_pkg::wr_blk_count;
					end
					sd_host_pkg::wr_blk_count: if (rsp_done) state <= sd_host_pkg::wr_argument;
					sd_host_pkg::wr_argument:  if (rsp_done) state <= sd_host_pkg::wr_tf_mode;
					sd_host_pkg::wr_tf_mode:   if (rsp_done) state <= sd_host_pkg::wr_command;
					sd_host_pkg::wr_command: if (rsp_done) begin
						state   <= sd_host_pkg::poll_cmd;
						restart <= 1'b1; // poll window opens
					end
					sd_host_pkg::poll_cmd: if (rsp_done) begin
						if (rdata[`SD_BIT_CMD_COMPLETE])
							state <= sd_host_pkg::clr_cmd;
						else if (expired) begin // only judged after a clear read
							fin_code <= sd_host_pkg::st_cmd_timeout;
							state    <= sd_host_pkg::finish;
						end
					end
					sd_host_pkg::clr_cmd: if (rsp_done) state <= sd_host_pkg::rd_resp;
					sd_host_pkg::rd_resp: if (rsp_done) begin
						if (rdata[`SD_BIT_READY_FOR_DATA]) begin
							state      <= sd_host_pkg::start_dma;
							start_adma <= 1'b1; // high for the start_dma cycle
						end else begin
							fin_code <= sd_host_pkg::st_not_ready;
							state    <= sd_host_pkg::finish;
						end
					end
					sd_host_pkg::start_dma: begin
						state   <= sd_host_pkg::poll_tf;
						restart <= 1'b1;
					end
					sd_host_pkg::poll_tf: if (rsp_done) begin
						if (rdata[`SD_BIT_TF_COMPLETE])
							state <= sd_host_pkg::clr_tf;
						else if (expired) begin
							fin_code <= sd_host_pkg::st_tf_timeout;
							state    <= sd_host_pkg::finish;
						end
					end
					sd_host_pkg::clr_tf: if (rsp_done) begin
						fin_code <= sd_host_pkg::st_ok;
						state    <= sd_host_pkg::finish;
					end
					sd_host_pkg::finish: begin // done and busy drop together
						done        <= 1'b1;
						busy        <= 1'b0;
						xfer_status <= fin_code;
						state       <= sd_host_pkg::idle;
					end
					default: state <= sd_host_pkg::idle;
				endcase
			end
		end
	end

	a_adma_in_start_dma: assert property (@(posedge clk) disable iff (reset)
		start_adma |-> (state == sd_host_pkg::start_dma));

	// relies on the master being back in idle once rsp_done is seen
	a_req_only_when_ready: assert property (@(posedge clk) disable iff (reset)
		req |-> ready);

endmodule

/* source/adma_xfer_top.sv */
`timescale 1ns/1ns
`include "sd_host_consts.svh"

module adma_xfer_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  logic [15:0]               blk_count,
	input  logic [31:0]               argument,
	input  logic [15:0]               tf_mode,
	input  logic [15:0]               command,
	output logic                      busy,
	output logic                      done,
	output logic                      start_adma,
	output sd_host_pkg::xfer_status_e xfer_status,
	output logic [`SD_ADDR_W-1:0]     paddr,
	output logic                      psel,
	output logic                      penable,
	output logic                      pwrite,
	output logic [`SD_DATA_W-1:0]     pwdata,
	input  logic [`SD_DATA_W-1:0]     prdata,
	input  logic                      pready,
	input  logic                      pslverr
);

	// sequencer to register master
	logic                      req;
	sd_host_pkg::reg_op_e      op;
	logic [`SD_ADDR_W-1:0]     addr;
	logic [`SD_DATA_W-1:0]     wdata;
	logic                      ready;
	logic                      rsp_done;
	logic [`SD_DATA_W-1:0]     rdata;
	logic                      rsp_err;
	logic                      restart; // poll window timer
	logic                      expired;

	xfer_sequencer seq_i (
		.clk, .reset, .start,
		.blk_count, .argument, .tf_mode, .command,
		.busy, .done, .start_adma, .xfer_status,
		.req, .op, .addr, .wdata,
		.ready, .rsp_done, .rdata, .rsp_err,
		.restart, .expired
	);

	apb_reg_master apb_i (
		.clk, .reset,
		.req, .op, .addr, .wdata,
		.ready, .rsp_done, .rdata, .rsp_err,
		.paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr
	);

	poll_timer #(.LIMIT(`SD_POLL_TIMEOUT)) timer_i (
		.clk, .reset, .restart, .expired
	);

endmodule

/* verif/sd_regmap_model.sv */
`timescale 1ns/1ns
`include "sd_host_consts.svh"

module sd_regmap_model (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`SD_ADDR_W-1:0] paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`SD_DATA_W-1:0] pwdata,
	output logic [`SD_DATA_W-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  logic                  start_adma,
	input  int                    cmd_delay, // -1 means never
	input  logic                  rfd,       // READY_FOR_DATA in the response
	input  int                    tf_delay,  // -1 means never
	input  logic                  err_en,
	input  logic [`SD_ADDR_W-1:0] err_addr
);

	logic [31:0] rng;
	logic [1:0]  waits;   // wait states left in this access
	logic [1:0]  stat;    // tf complete, cmd complete
	logic [1:0]  stat_nx;
	int          cmd_t;   // countdown to cmd complete
	int          tf_t;    // countdown to tf complete

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	assign pready  = psel && penable && (waits == 2'd0);
	assign pslverr = pready && err_en && (paddr == err_addr);
	assign prdata  = (paddr == `SD_REG_NORM_INT_STAT) ? {30'b0, stat} :
		(paddr == `SD_REG_RESPONSE) ? (32'(rfd) << `SD_BIT_READY_FOR_DATA) : '0;

	// w1c first, a new event in the same cycle wins
	always_comb begin
		stat_nx = stat;
		if (pready && pwrite && !pslverr && paddr == `SD_REG_NORM_INT_STAT)
			stat_nx = stat_nx & ~pwdata[1:0];
		if (cmd_t == 0)
			stat_nx[`SD_BIT_CMD_COMPLETE] = 1'b1;
		if (tf_t == 0)
			stat_nx[`SD_BIT_TF_COMPLETE] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rng   <= 32'h7bda8ff9;
			waits <= 2'd0;
			stat  <= 2'd0;
			cmd_t <= -1;
			tf_t  <= -1;
		end else begin
			stat <= stat_nx;
			if (psel && !penable) begin // setup phase draws 0..3 waits
				rng   <= xorshift32(rng);
				waits <= rng[1:0];
			end else if (penable && waits != 2'd0)
				waits <= waits - 2'd1;
			cmd_t <= (cmd_t > 0) ? cmd_t - 1 : -1;
			tf_t  <= (tf_t > 0) ? tf_t - 1 : -1;
			if (pready && pwrite && !pslverr && paddr == `SD_REG_COMMAND && cmd_delay >= 0)
				cmd_t <= cmd_delay; // command sent, response on its way
			if (start_adma && tf_delay >= 0)
				tf_t <= tf_delay;
		end
	end

endmodule

/* verif/tb_adma_xfer.sv */
`timescale 1ns/1ns
`include "sd_host_consts.svh"

module tb_adma_xfer;

	localparam int CYCLE_LIMIT = 6 * (3 * `SD_POLL_TIMEOUT + 200);

	logic                      clk = 1'b0;
	logic                      reset;
	logic                      start;
	logic [15:0]               blk_count;
	logic [31:0]               argument;
	logic [15:0]               tf_mode;
	logic [15:0]               command;
	logic                      busy;
	logic                      done;
	logic                      start_adma;
	sd_host_pkg::xfer_status_e xfer_status;
	logic [`SD_ADDR_W-1:0]     paddr;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [`SD_DATA_W-1:0]     pwdata;
	logic [`SD_DATA_W-1:0]     prdata;
	logic                      pready;
	logic                      pslverr;
	int                        cmd_delay;
	logic                      rfd;
	int                        tf_delay;
	logic                      err_en;
	logic [`SD_ADDR_W-1:0]     err_addr;

	// expected and observed per transfer
	logic [43:0]               exp_wr [0:5]; // {paddr, pwdata}
	int                        exp_n;
	int                        exp_adma;
	sd_host_pkg::xfer_status_e exp_st;
	logic [43:0]               got_wr [$];
	int                        adma_cnt;
	int                        done_cnt;
	int                        late_xfers;   // transfers after a slave error
	logic                      err_seen;
	logic                      checked;
	int                        test_errs;
	int                        n_pass = 0;
	int                        n_fail = 0;
	int                        cycles = 0;

	always #2 clk = ~clk;

	adma_xfer_top adma_xfer_top_i (
		.clk, .reset, .start,
		.blk_count, .argument, .tf_mode, .command,
		.busy, .done, .start_adma, .xfer_status,
		.paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr
	);

	sd_regmap_model regmap_i (
		.clk, .reset,
		.paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr,
		.start_adma, .cmd_delay, .rfd, .tf_delay, .err_en, .err_addr
	);

	// ------------------------------------------------------------------------
	// reference model of one transfer
	// ------------------------------------------------------------------------
	function automatic void expected_result(
		input int cmd_d, input logic rdy, input int tf_d,
		input logic e_en, input logic [11:0] e_addr,
		input logic [15:0] bc, input logic [31:0] arg, input logic [15:0] tm,
		input logic [15:0] cmd,
		output logic [43:0] wr [0:5], output int n, output int adma,
		output sd_host_pkg::xfer_status_e st);
		logic [11:0] a [0:3];
		logic [31:0] d [0:3];
		a = '{`SD_REG_BLK_COUNT, `SD_REG_ARGUMENT, `SD_REG_TF_MODE, `SD_REG_COMMAND};
		d = '{32'(bc), arg, 32'(tm), 32'(cmd)};
		n = 0;
		adma = 0;
		st = sd_host_pkg::st_bus_error; // every early return below is a slave error
		for (int i = 0; i < 4; i++) begin
			wr[n] = {a[i], d[i]};
			n++;
			if (e_en && e_addr == a[i])
				return;
		end
		if (e_en && e_addr == `SD_REG_NORM_INT_STAT)
			return; // first status poll
		if (cmd_d < 0) begin
			st = sd_host_pkg::st_cmd_timeout;
			return;
		end
		wr[n] = {12'(`SD_REG_NORM_INT_STAT), 32'h1}; // clear cmd complete
		n++;
		if (e_en && e_addr == `SD_REG_RESPONSE)
			return;
		if (!rdy) begin
			st = sd_host_pkg::st_not_ready;
			return;
		end
		adma = 1;
		if (tf_d < 0) begin
			st = sd_host_pkg::st_tf_timeout;
			return;
		end
		wr[n] = {12'(`SD_REG_NORM_INT_STAT), 32'h2};
		n++;
		st = sd_host_pkg::st_ok;
	endfunction

	task automatic compare_result();
		if (got_wr.size() != exp_n) begin
			$display("write count mismatch: %0d APB writes seen, %0d expected",
				got_wr.size(), exp_n);
			test_errs++;
		end
		for (int i = 0; i < exp_n && i < got_wr.size(); i++) begin
			if (got_wr[i][43:32] != exp_wr[i][43:32]) begin
				$display("error: paddr of write %0d got 0x%h expected 0x%h",
					i, got_wr[i][43:32], exp_wr[i][43:32]);
				test_errs++;
			end
			if (got_wr[i][31:0] != exp_wr[i][31:0]) begin
				$display("error: pwdata of write %0d got 0x%h expected 0x%h",
					i, got_wr[i][31:0], exp_wr[i][31:0]);
				test_errs++;
			end
		end
		if (adma_cnt != exp_adma) begin
			$display("start_adma pulsed %0d times, %0d expected", adma_cnt, exp_adma);
			test_errs++;
		end
		if (late_xfers != 0) begin
			$display("APB transfer issued after a slave error");
			test_errs++;
		end
		if (xfer_status != exp_st) begin
			$display("error: xfer_status got 0x%h expected 0x%h", xfer_status, exp_st);
			test_errs++;
		end
	endtask

	// bus monitor and checks at done, sampled between rising edges
	always @(negedge clk) begin
		if (!reset) begin
			if (psel && penable && pready) begin
				if (err_seen)
					late_xfers++;
				if (pwrite)
					got_wr.push_back({paddr, pwdata});
				if (pslverr)
					err_seen = 1'b1;
			end
			if (start_adma)
				adma_cnt++;
			if (done) begin
				done_cnt++;
				compare_result();
				checked = 1'b1;
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, a transfer never finished", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic run_transfer(input string name, input int cmd_d, input logic rdy,
		input int tf_d, input logic e_en, input logic [11:0] e_addr,
		input logic [15:0] bc, input logic [31:0] arg, input logic [15:0] tm,
		input logic [15:0] cmd, input logic poke);
		@(negedge clk);
		cmd_delay  = cmd_d;
		rfd        = rdy;
		tf_delay   = tf_d;
		err_en     = e_en;
		err_addr   = e_addr;
		got_wr.delete();
		adma_cnt   = 0;
		done_cnt   = 0;
		late_xfers = 0;
		err_seen   = 1'b0;
		checked    = 1'b0;
		test_errs  = 0;
		expected_result(cmd_d, rdy, tf_d, e_en, e_addr, bc, arg, tm, cmd,
			exp_wr, exp_n, exp_adma, exp_st);
		blk_count = bc;
		argument  = arg;
		tf_mode   = tm;
		command   = cmd;
		start     = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (poke) begin // second start mid transfer, must be dropped
			repeat (6) @(negedge clk);
			blk_count = ~bc;
			argument  = ~arg;
			tf_mode   = ~tm; // still to be written, shows a stray latch
			command   = ~cmd;
			start     = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		while (!checked)
			@(negedge clk);
		repeat (8) @(negedge clk); // room for a stray done
		if (done_cnt != 1) begin
			$display("%0d done pulses seen where one was expected", done_cnt);
			test_errs++;
		end
		if (busy) begin
			$display("busy still high after done");
			test_errs++;
		end
		if (test_errs == 0) begin
			n_pass++;
			$display("test %s: ok", name);
		end else begin
			n_fail++;
			$display("test %s: %0d mismatches", name, test_errs);
		end
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		reset     = 1'b1;
		start     = 1'b0;
		blk_count = '0;
		argument  = '0;
		tf_mode   = '0;
		command   = '0;
		cmd_delay = -1;
		rfd       = 1'b0;
		tf_delay  = -1;
		err_en    = 1'b0;
		err_addr  = '0;
		checked   = 1'b0;
		err_seen  = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		run_transfer("normal", 10, 1'b1, 20, 1'b0, 12'h000,
			16'h0010, 32'h0000_1200, 16'h0023, 16'h123a, 1'b0);
		run_transfer("not_ready", 5, 1'b0, 20, 1'b0, 12'h000,
			16'h0001, 32'h0000_0040, 16'h0013, 16'h113a, 1'b0);
		run_transfer("cmd_timeout", -1, 1'b1, 20, 1'b0, 12'h000,
			16'h0004, 32'h0001_0000, 16'h0023, 16'h123a, 1'b0);
		run_transfer("tf_timeout", 5, 1'b1, -1, 1'b0, 12'h000,
			16'h0008, 32'h0002_0800, 16'h0033, 16'h193a, 1'b0);
		run_transfer("bus_error", 5, 1'b1, 20, 1'b1, `SD_REG_ARGUMENT,
			16'h0002, 32'h0000_3000, 16'h0023, 16'h123a, 1'b0);
		run_transfer("start_while_busy", 12, 1'b1, 30, 1'b0, 12'h000,
			16'h0020, 32'h00ab_cd00, 16'h0027, 16'h193a, 1'b1);
		run_transfer("back_to_back", 3, 1'b1, 7, 1'b0, 12'h000,
			16'hbeef, 32'hdead_0042, 16'h0037, 16'h113a, 1'b0);
		$display("%0d transfers run, %0d ok, %0d with mismatches",
			n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* compile.f */
+incdir+source
source/sd_host_pkg.sv
source/apb_reg_master.sv
source/poll_timer.sv
source/xfer_sequencer.sv
source/adma_xfer_top.sv
verif/sd_regmap_model.sv
verif/tb_adma_xfer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ADMA sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_adma_xfer \
	-Mdir obj_dir -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
